// ==== dv/ncpu32k_tb.sv ====
/*
 * Testbench for the three-stage core
 * Every table row runs the same short program shape: load A and B,
 * apply one operation, store the result, then spin on a self-jump
 * Only one store per program, at the result address
 * Both bus models answer a held request after 0 to 3 random waits
 */
`timescale 1ns/10ps
`include "ncpu32k_macros.svh"

module ncpu32k_tb;
   localparam int NUM_ROWS        = 23;
   localparam int WATCHDOG_CYCLES = NUM_ROWS * 200;
   localparam logic [15:0] A_OFS   = 16'h0100;  // Operand words in data memory
   localparam logic [15:0] B_OFS   = 16'h0104;
   localparam logic [15:0] RES_OFS = 16'h0200;  // Result store target
   localparam logic [15:0] HALT_PC = 16'h0018;

   logic                clk_i;
   logic                rst_n_i;
   logic [`NCPU_DW-1:0] d_i, d_o;
   logic [`NCPU_IW-1:0] insn_i;
   logic                insn_ready_i, dbus_rd_ready_i, dbus_we_done_i;
   logic [`NCPU_AW-1:0] addr_o, iaddr_o;
   logic                dbus_rd_o, dbus_we_o, ibus_rd_o;

   logic [`NCPU_IW-1:0] imem [0:63];
   logic [`NCPU_DW-1:0] dmem [0:1023];
   integer              seed = 32'h6e32_2d16;
   int                  iwait, dwait;      // Remaining wait cycles per bus
   logic                reset_req;         // Applied by the bus driver
   logic                store_seen;
   logic [`NCPU_AW-1:0] st_addr;
   logic [`NCPU_DW-1:0] st_data;
   int                  row_count;

   // Test table
   string                row_name [NUM_ROWS];
   ncpu32k_pkg::opcode_e row_opc  [NUM_ROWS];
   logic [31:0]          row_a    [NUM_ROWS];
   logic [31:0]          row_b    [NUM_ROWS];  // Low half is the ADDI immediate
   logic [4:0]           row_dst  [NUM_ROWS];  // Result and store register
   logic [31:0]          row_exp  [NUM_ROWS];

   ncpu32k_core DUT (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .d_i             (d_i),
      .insn_i          (insn_i),
      .insn_ready_i    (insn_ready_i),
      .dbus_rd_ready_i (dbus_rd_ready_i),
      .dbus_we_done_i  (dbus_we_done_i),
      .d_o             (d_o),
      .addr_o          (addr_o),
      .dbus_rd_o       (dbus_rd_o),
      .dbus_we_o       (dbus_we_o),
      .iaddr_o         (iaddr_o),
      .ibus_rd_o       (ibus_rd_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;  // 8 ns period
   end

   ////////////////////////////////////////////////////////////
   // Assembler
   ////////////////////////////////////////////////////////////

   function automatic logic [`NCPU_IW-1:0] r_type(input ncpu32k_pkg::opcode_e opc,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
      logic [`NCPU_IW-1:0] w;
      w = '0;
      w[ncpu32k_pkg::OPC_MSB:ncpu32k_pkg::OPC_LSB] = opc;
      w[ncpu32k_pkg::RD_MSB:ncpu32k_pkg::RD_LSB]   = rd;
      w[ncpu32k_pkg::RS1_MSB:ncpu32k_pkg::RS1_LSB] = rs1;
      w[ncpu32k_pkg::RS2_MSB:ncpu32k_pkg::RS2_LSB] = rs2;
      return w;
   endfunction

   function automatic logic [`NCPU_IW-1:0] i_type(input ncpu32k_pkg::opcode_e opc,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [15:0] imm);
      logic [`NCPU_IW-1:0] w;
      w = '0;
      w[ncpu32k_pkg::OPC_MSB:ncpu32k_pkg::OPC_LSB] = opc;
      w[ncpu32k_pkg::RD_MSB:ncpu32k_pkg::RD_LSB]   = rd;   // Data register for STW
      w[ncpu32k_pkg::RS1_MSB:ncpu32k_pkg::RS1_LSB] = rs1;
      w[ncpu32k_pkg::IMM_MSB:ncpu32k_pkg::IMM_LSB] = imm;
      return w;
   endfunction

   task automatic add_row(input string name, input ncpu32k_pkg::opcode_e opc,
                          input logic [31:0] a, input logic [31:0] b,
                          input logic [4:0] dst, input logic [31:0] exp_val);
      row_name[row_count] = name;
      row_opc[row_count]  = opc;
      row_a[row_count]    = a;
      row_b[row_count]    = b;
      row_dst[row_count]  = dst;
      row_exp[row_count]  = exp_val;
      row_count++;
   endtask

   task automatic build_table();
      add_row("and_mixed",      ncpu32k_pkg::OPC_AND,  32'hf0f0_a5a5, 32'h0ff0_5a3c, 3, 32'h00f0_0024);
      add_row("or_mixed",       ncpu32k_pkg::OPC_OR,   32'hf0f0_a5a5, 32'h0ff0_5a3c, 3, 32'hfff0_ffbd);
      add_row("xor_mixed",      ncpu32k_pkg::OPC_XOR,  32'hf0f0_a5a5, 32'h0ff0_5a3c, 3, 32'hff00_ff99);
      add_row("lsl_by_0",       ncpu32k_pkg::OPC_LSL,  32'h8000_0001, 32'h0000_0000, 3, 32'h8000_0001);
      add_row("lsl_by_1",       ncpu32k_pkg::OPC_LSL,  32'h8000_0001, 32'h0000_0001, 3, 32'h0000_0002);
      add_row("lsl_by_31",      ncpu32k_pkg::OPC_LSL,  32'h0000_0003, 32'h0000_001f, 3, 32'h8000_0000);
      add_row("lsl_upper_bits", ncpu32k_pkg::OPC_LSL,  32'h0000_00ff, 32'hffff_ffe4, 3, 32'h0000_0ff0);
      add_row("lsr_by_0",       ncpu32k_pkg::OPC_LSR,  32'hf000_000f, 32'h0000_0000, 3, 32'hf000_000f);
      add_row("lsr_by_1",       ncpu32k_pkg::OPC_LSR,  32'h8000_0000, 32'h0000_0001, 3, 32'h4000_0000);
      add_row("lsr_by_31",      ncpu32k_pkg::OPC_LSR,  32'hffff_ffff, 32'h0000_001f, 3, 32'h0000_0001);
      add_row("lsr_upper_bits", ncpu32k_pkg::OPC_LSR,  32'hf000_0000, 32'h0000_0124, 3, 32'h0f00_0000);
      add_row("asr_neg_by_1",   ncpu32k_pkg::OPC_ASR,  32'h8000_0000, 32'h0000_0001, 3, 32'hc000_0000);
      add_row("asr_neg_by_31",  ncpu32k_pkg::OPC_ASR,  32'h8000_0000, 32'h0000_001f, 3, 32'hffff_ffff);
      add_row("asr_pos_by_4",   ncpu32k_pkg::OPC_ASR,  32'h7000_0000, 32'h0000_0004, 3, 32'h0700_0000);
      add_row("asr_upper_bits", ncpu32k_pkg::OPC_ASR,  32'hf000_00f0, 32'h0000_0028, 3, 32'hfff0_0000);
      add_row("asr_by_0",       ncpu32k_pkg::OPC_ASR,  32'h8765_4321, 32'h0000_0000, 3, 32'h8765_4321);
      add_row("add_simple",     ncpu32k_pkg::OPC_ADD,  32'h0000_1234, 32'h0000_4321, 3, 32'h0000_5555);
      add_row("add_wrap",       ncpu32k_pkg::OPC_ADD,  32'hffff_fffe, 32'h0000_0005, 3, 32'h0000_0003);
      add_row("addi_neg",       ncpu32k_pkg::OPC_ADDI, 32'h0000_0010, 32'h0000_fff0, 3, 32'h0000_0000);
      add_row("addi_neg_wrap",  ncpu32k_pkg::OPC_ADDI, 32'h0000_0005, 32'h0000_8000, 3, 32'hffff_8005);
      add_row("addi_pos",       ncpu32k_pkg::OPC_ADDI, 32'h1000_0000, 32'h0000_7fff, 3, 32'h1000_7fff);
      // A is the jump target, link is the jump PC 0x0c plus 4
      add_row("jmpreg_link",    ncpu32k_pkg::OPC_JMPREG, 32'h0000_0014, 32'h0, 3, 32'h0000_0010);
      add_row("r0_write",       ncpu32k_pkg::OPC_ADD,  32'h1234_5678, 32'h0000_0001, 0, 32'h0000_0000);
   endtask

   // Fill memories and place the program of one row
   task automatic load_row(input int idx);
      logic [`NCPU_IW-1:0] op_insn;
      logic [`NCPU_IW-1:0] slot_insn;   // Right behind the operation
      logic [`NCPU_IW-1:0] tail_insn;   // Just before the halt
      for (int i = 0; i < 64; i++) begin
         imem[i] = i & 32'h03ff_ffff;  // NOP tagged with its index
      end
      for (int i = 0; i < 1024; i++) begin
         dmem[i] = 32'hc3a5_0000 ^ (i * 32'h0001_0007);
      end
      dmem[A_OFS[11:2]] = row_a[idx];
      dmem[B_OFS[11:2]] = row_b[idx];
      // Store reads the result register straight after its write
      slot_insn = i_type(ncpu32k_pkg::OPC_STW, row_dst[idx], 5'd0, RES_OFS);
      tail_insn = r_type(ncpu32k_pkg::OPC_NOP, 5'd0, 5'd0, 5'd0);
      case (row_opc[idx])
         ncpu32k_pkg::OPC_ADDI:
            op_insn = i_type(ncpu32k_pkg::OPC_ADDI, row_dst[idx], 5'd1, row_b[idx][15:0]);
         ncpu32k_pkg::OPC_JMPREG: begin
            op_insn   = r_type(ncpu32k_pkg::OPC_JMPREG, row_dst[idx], 5'd1, 5'd0);
            slot_insn = i_type(ncpu32k_pkg::OPC_ADDI, row_dst[idx], 5'd0, 16'hffff);  // Skipped
            tail_insn = i_type(ncpu32k_pkg::OPC_STW, row_dst[idx], 5'd0, RES_OFS);  // Target
         end
         default:
            op_insn = r_type(row_opc[idx], row_dst[idx], 5'd1, 5'd2);
      endcase
      imem[0] = i_type(ncpu32k_pkg::OPC_ADDI, 5'd4, 5'd0, HALT_PC);  // r4 = halt address
      imem[1] = i_type(ncpu32k_pkg::OPC_LDW, 5'd1, 5'd0, A_OFS);
      imem[2] = i_type(ncpu32k_pkg::OPC_LDW, 5'd2, 5'd0, B_OFS);
      imem[3] = op_insn;   // Uses r2 straight after its load
      imem[4] = slot_insn;
      imem[5] = tail_insn;
      imem[6] = r_type(ncpu32k_pkg::OPC_JMPREG, 5'd0, 5'd4, 5'd0);  // Self-jump halt
   endtask

   function automatic int draw_wait();
      return $random(seed) & 3;
   endfunction

   ////////////////////////////////////////////////////////////
   // Bus models and reset, all driven 1 ns after the edge
   ////////////////////////////////////////////////////////////

   initial begin
      forever begin
         @(posedge clk_i);
         #1;
         rst_n_i         = ~reset_req;
         insn_ready_i    = 1'b0;  // Strobes last one cycle
         dbus_rd_ready_i = 1'b0;
         dbus_we_done_i  = 1'b0;
         if (!reset_req) begin
            if (ibus_rd_o) begin
               if (iwait == 0) begin
                  insn_i       = imem[iaddr_o[7:2]];
                  insn_ready_i = 1'b1;
                  iwait        = draw_wait();
               end else begin
                  iwait--;
               end
            end
            if (dbus_rd_o || dbus_we_o) begin
               if (dwait == 0) begin
                  if (dbus_rd_o) begin
                     d_i             = dmem[addr_o[11:2]];
                     dbus_rd_ready_i = 1'b1;
                  end else begin
                     dmem[addr_o[11:2]] = d_o;
                     st_addr            = addr_o;
                     st_data            = d_o;
                     store_seen         = 1'b1;
                     dbus_we_done_i     = 1'b1;
                  end
                  dwait = draw_wait();
               end else begin
                  dwait--;
               end
            end
         end
      end
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
         $display("Checks failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic run_row(input int idx);
      @(posedge clk_i);
      reset_req  = 1'b1;
      store_seen = 1'b0;
      load_row(idx);
      repeat (4) @(posedge clk_i);  // Reset held 4 cycles
      reset_req = 1'b0;
      wait (store_seen);
      check_value(row_name[idx], {16'h0, RES_OFS}, st_addr);
      check_value(row_name[idx], row_exp[idx], st_data);
   endtask

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("Timeout: the program never stored its result");
      $display("Checks failed");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      rst_n_i         = 1'b0;
      reset_req       = 1'b1;
      d_i             = '0;
      insn_i          = '0;
      insn_ready_i    = 1'b0;
      dbus_rd_ready_i = 1'b0;
      dbus_we_done_i  = 1'b0;
      store_seen      = 1'b0;
      iwait           = 0;
      dwait           = 0;
      row_count       = 0;
      build_table();
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_row(r);
      end
      $display("All checks passed");
      $finish;
   end

endmodule

// ==== ncpu32k.f ====
+incdir+verilog
verilog/ncpu32k_pkg.sv
verilog/ncpu32k_exc_if.sv
verilog/ncpu32k_regfile.sv
verilog/ncpu32k_fetch.sv
verilog/ncpu32k_decode.sv
verilog/ncpu32k_execute.sv
verilog/ncpu32k_core.sv
dv/ncpu32k_tb.sv

// ==== verilog/ncpu32k_core.sv ====
/*
 * Three-stage in-order core top level
 * Instruction and data buses are request levels held until the strobe
 * A stage advances only when every later stage is ready
 */
`timescale 1ns/10ps
`include "ncpu32k_macros.svh"

module ncpu32k_core (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic [`NCPU_DW-1:0] d_i,              // Load data
   input  logic [`NCPU_IW-1:0] insn_i,           // Instruction word
   input  logic                insn_ready_i,     // Instruction returned
   input  logic                dbus_rd_ready_i,  // Load data valid
   input  logic                dbus_we_done_i,   // Store accepted
   output logic [`NCPU_DW-1:0] d_o,              // Store data
   output logic [`NCPU_AW-1:0] addr_o,
   output logic                dbus_rd_o,
   output logic                dbus_we_o,
   output logic [`NCPU_AW-1:0] iaddr_o,
   output logic                ibus_rd_o
);
   logic [`NCPU_REG_AW-1:0] rs1_addr, rs2_addr, rd_addr;
   logic [`NCPU_DW-1:0]     rs1, rs2, rd;
   logic                    rd_we;
   logic [`NCPU_IW-1:0]     insn;
   logic [`NCPU_AW-1:0]     insn_pc;
   logic                    insn_valid;
   logic                    jmp;
   logic [`NCPU_AW-1:0]     jmp_addr;
   logic                    pipe1_flow, pipe2_flow, pipe3_flow;
   logic                    pipe1_ready;

   ncpu32k_exc_if exc_bus ();

   //////////////////////////////////////////////////////////////
   // Flow chain
   //////////////////////////////////////////////////////////////

   assign pipe1_ready = insn_valid;     // Fetch holds a word
   assign pipe3_flow  = exc_bus.pipe3_ready;
   assign pipe2_flow  = pipe3_flow;     // Decode never stalls
   assign pipe1_flow  = pipe2_flow & pipe1_ready;

   ncpu32k_regfile regfile0 (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .rd_addr_i  (rd_addr),
      .rd_i       (rd),
      .rd_we_i    (rd_we),
      .rs1_o      (rs1),
      .rs2_o      (rs2)
   );

   ncpu32k_fetch fetch0 (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .insn_i       (insn_i),
      .insn_ready_i (insn_ready_i),
      .pipe1_flow_i (pipe1_flow),
      .jmp_i        (jmp),
      .jmp_addr_i   (jmp_addr),
      .iaddr_o      (iaddr_o),
      .ibus_rd_o    (ibus_rd_o),
      .insn_o       (insn),
      .insn_pc_o    (insn_pc),
      .insn_valid_o (insn_valid)
   );

   ncpu32k_decode decode0 (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .insn_i       (insn),
      .insn_pc_i    (insn_pc),
      .insn_valid_i (insn_valid),
      .pipe2_flow_i (pipe2_flow),
      .flush_i      (jmp),              // Squash the word behind a jump
      .rs1_addr_o   (rs1_addr),
      .rs2_addr_o   (rs2_addr),
      .rs1_i        (rs1),
      .rs2_i        (rs2),
      .exc          (exc_bus.dec)
   );

   ncpu32k_execute execute0 (
      .exc             (exc_bus.exc),
      .d_i             (d_i),
      .dbus_rd_ready_i (dbus_rd_ready_i),
      .dbus_we_done_i  (dbus_we_done_i),
      .d_o             (d_o),
      .addr_o          (addr_o),
      .dbus_rd_o       (dbus_rd_o),
      .dbus_we_o       (dbus_we_o),
      .rd_addr_o       (rd_addr),
      .rd_o            (rd),
      .rd_we_o         (rd_we),
      .jmp_o           (jmp),
      .jmp_addr_o      (jmp_addr)
   );

endmodule

// ==== verilog/ncpu32k_decode.sv ====
/*
 * Decode stage and the decode-to-execute pipeline register
 * Register operands are read in the same cycle as write-back
 * STW reads its store data through the rd field on the rs2 port
 * Unknown opcodes become NOP
 */
`timescale 1ns/10ps
`include "ncpu32k_macros.svh"

module ncpu32k_decode (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic [`NCPU_IW-1:0]     insn_i,
   input  logic [`NCPU_AW-1:0]     insn_pc_i,
   input  logic                    insn_valid_i,
   input  logic                    pipe2_flow_i,
   input  logic                    flush_i,       // Jump taken in execute
   output logic [`NCPU_REG_AW-1:0] rs1_addr_o,
   output logic [`NCPU_REG_AW-1:0] rs2_addr_o,
   input  logic [`NCPU_DW-1:0]     rs1_i,
   input  logic [`NCPU_DW-1:0]     rs2_i,
   ncpu32k_exc_if.dec              exc
);
   localparam int IMM_W = ncpu32k_pkg::IMM_MSB - ncpu32k_pkg::IMM_LSB + 1;

   logic [$bits(ncpu32k_pkg::opcode_e)-1:0] opc_field;
   ncpu32k_pkg::opcode_e    opc;
   logic [`NCPU_REG_AW-1:0] rd_addr;
   logic [IMM_W-1:0]        imm;
   logic [`NCPU_DW-1:0]     imm_sext;
   logic                    use_imm;  // operand_2 from the immediate
   logic                    writes_rd;

   //////////////////////////////////////////////////////////////
   // Field extraction
   //////////////////////////////////////////////////////////////

   assign opc_field = insn_i[ncpu32k_pkg::OPC_MSB:ncpu32k_pkg::OPC_LSB];
   assign rd_addr   = insn_i[ncpu32k_pkg::RD_MSB:ncpu32k_pkg::RD_LSB];
   assign imm       = insn_i[ncpu32k_pkg::IMM_MSB:ncpu32k_pkg::IMM_LSB];
   assign imm_sext  = {{(`NCPU_DW-IMM_W){imm[IMM_W-1]}}, imm};

   always_comb begin
      opc       = ncpu32k_pkg::OPC_NOP;
      use_imm   = 1'b0;
      writes_rd = 1'b0;
      case (opc_field)
         ncpu32k_pkg::OPC_AND, ncpu32k_pkg::OPC_OR, ncpu32k_pkg::OPC_XOR,
         ncpu32k_pkg::OPC_LSL, ncpu32k_pkg::OPC_LSR, ncpu32k_pkg::OPC_ASR,
         ncpu32k_pkg::OPC_ADD, ncpu32k_pkg::OPC_JMPREG: begin
            opc       = ncpu32k_pkg::opcode_e'(opc_field);
            writes_rd = 1'b1;
         end
         ncpu32k_pkg::OPC_ADDI, ncpu32k_pkg::OPC_LDW: begin
            opc       = ncpu32k_pkg::opcode_e'(opc_field);
            use_imm   = 1'b1;
            writes_rd = 1'b1;
         end
         ncpu32k_pkg::OPC_STW: begin
            opc       = ncpu32k_pkg::OPC_STW;
            use_imm   = 1'b1;   // Offset, no register written
         end
         default: ;             // NOP
      endcase
   end

   // Operand read
   assign rs1_addr_o = insn_i[ncpu32k_pkg::RS1_MSB:ncpu32k_pkg::RS1_LSB];
   assign rs2_addr_o = (opc == ncpu32k_pkg::OPC_STW) ? rd_addr :
                       insn_i[ncpu32k_pkg::RS2_MSB:ncpu32k_pkg::RS2_LSB];

   //////////////////////////////////////////////////////////////
   // Pipeline register
   //////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         exc.valid <= 1'b0;
      else if (pipe2_flow_i)
         exc.valid <= insn_valid_i & ~flush_i;  // Bubble otherwise
   end

   always_ff @(posedge clk_i) begin
      if (pipe2_flow_i) begin
         exc.opcode      <= opc;
         exc.operand_1   <= rs1_i;
         exc.operand_2   <= use_imm ? imm_sext : rs2_i;
         exc.store_data  <= rs2_i;
         exc.wb_reg_addr <= rd_addr;
         exc.wb_en       <= writes_rd & (rd_addr != '0);
         exc.insn_pc     <= insn_pc_i;
      end
   end

endmodule

// ==== verilog/ncpu32k_exc_if.sv ====
/*
 * Decode-to-execute bundle
 * Everything except pipe3_ready comes from the decode pipeline register
 */
`timescale 1ns/10ps
`include "ncpu32k_macros.svh"

interface ncpu32k_exc_if;
   logic                     valid;        // Slot holds a live instruction
   ncpu32k_pkg::opcode_e     opcode;
   logic [`NCPU_DW-1:0]      operand_1;    // rs1
   logic [`NCPU_DW-1:0]      operand_2;    // rs2 or sign-extended immediate
   logic [`NCPU_DW-1:0]      store_data;
   logic [`NCPU_REG_AW-1:0]  wb_reg_addr;
   logic                     wb_en;        // Already cleared for rd == 0
   logic [`NCPU_AW-1:0]      insn_pc;
   logic                     pipe3_ready;  // Execute retires this cycle

   modport dec (
      output valid, opcode, operand_1, operand_2, store_data,
      output wb_reg_addr, wb_en, insn_pc
   );

   modport exc (
      input  valid, opcode, operand_1, operand_2, store_data,
      input  wb_reg_addr, wb_en, insn_pc,
      output pipe3_ready
   );
endinterface

// ==== verilog/ncpu32k_execute.sv ====
/*
 * Execute stage with logic, arithmetic and memory units plus write-back
 * ALU ops and jumps retire in one cycle
 * Loads and stores hold the data bus until its ready or done strobe
 * Shift amounts use only the low five bits of operand_2
 */
`timescale 1ns/10ps
`include "ncpu32k_macros.svh"

module ncpu32k_execute (
   ncpu32k_exc_if.exc              exc,
   input  logic [`NCPU_DW-1:0]     d_i,
   input  logic                    dbus_rd_ready_i,
   input  logic                    dbus_we_done_i,
   output logic [`NCPU_DW-1:0]     d_o,
   output logic [`NCPU_AW-1:0]     addr_o,
   output logic                    dbus_rd_o,
   output logic                    dbus_we_o,
   output logic [`NCPU_REG_AW-1:0] rd_addr_o,
   output logic [`NCPU_DW-1:0]     rd_o,
   output logic                    rd_we_o,
   output logic                    jmp_o,
   output logic [`NCPU_AW-1:0]     jmp_addr_o
);
   logic op_and, op_or, op_xor;
   logic op_lsl, op_lsr, op_asr, op_shift;
   logic op_add, op_load, op_store, op_jmp;

   logic [`NCPU_DW-1:0]   lu_and, lu_or, lu_xor;
   logic [`NCPU_DW-1:0]   shift_lsw;   // Reversed for left shifts
   logic [`NCPU_DW-1:0]   shift_msw;   // Sign fill for ASR
   logic [2*`NCPU_DW-1:0] shift_wide;
   logic [`NCPU_DW-1:0]   shift_right;
   logic [`NCPU_DW-1:0]   lu_shift;
   logic [`NCPU_DW-1:0]   au_sum;
   logic [`NCPU_DW-1:0]   linkaddr;

   // One-hot opcode bits, dead when the slot is empty
   assign op_and   = exc.valid & (exc.opcode == ncpu32k_pkg::OPC_AND);
   assign op_or    = exc.valid & (exc.opcode == ncpu32k_pkg::OPC_OR);
   assign op_xor   = exc.valid & (exc.opcode == ncpu32k_pkg::OPC_XOR);
   assign op_lsl   = exc.valid & (exc.opcode == ncpu32k_pkg::OPC_LSL);
   assign op_lsr   = exc.valid & (exc.opcode == ncpu32k_pkg::OPC_LSR);
   assign op_asr   = exc.valid & (exc.opcode == ncpu32k_pkg::OPC_ASR);
   assign op_add   = exc.valid & ((exc.opcode == ncpu32k_pkg::OPC_ADD) |
                                  (exc.opcode == ncpu32k_pkg::OPC_ADDI));
   assign op_load  = exc.valid & (exc.opcode == ncpu32k_pkg::OPC_LDW);
   assign op_store = exc.valid & (exc.opcode == ncpu32k_pkg::OPC_STW);
   assign op_jmp   = exc.valid & (exc.opcode == ncpu32k_pkg::OPC_JMPREG);
   assign op_shift = op_lsl | op_lsr | op_asr;

   //////////////////////////////////////////////////////////////
   // Logic unit
   //////////////////////////////////////////////////////////////

   assign lu_and = exc.operand_1 & exc.operand_2;
   assign lu_or  = exc.operand_1 | exc.operand_2;
   assign lu_xor = exc.operand_1 ^ exc.operand_2;

   function automatic logic [`NCPU_DW-1:0] reverse_bits(input logic [`NCPU_DW-1:0] a);
      logic [`NCPU_DW-1:0] r;
      for (int i = 0; i < `NCPU_DW; i++) begin
         r[`NCPU_DW-1-i] = a[i];
      end
      return r;
   endfunction

   // Left shift done as a right shift of the reversed word
   assign shift_lsw   = op_lsl ? reverse_bits(exc.operand_1) : exc.operand_1;
   assign shift_msw   = op_asr ? {`NCPU_DW{exc.operand_1[`NCPU_DW-1]}} : '0;
   assign shift_wide  = {shift_msw, shift_lsw} >> exc.operand_2[4:0];
   assign shift_right = shift_wide[`NCPU_DW-1:0];
   assign lu_shift    = op_lsl ? reverse_bits(shift_right) : shift_right;

   //////////////////////////////////////////////////////////////
   // Arithmetic and memory units
   //////////////////////////////////////////////////////////////

   assign au_sum = exc.operand_1 + exc.operand_2;  // Also base + offset

   assign addr_o    = au_sum[`NCPU_AW-1:0];
   assign d_o       = exc.store_data;
   assign dbus_rd_o = op_load;
   assign dbus_we_o = op_store;

   // Stall until the bus strobe on loads and stores
   assign exc.pipe3_ready = op_load  ? dbus_rd_ready_i :
                            op_store ? dbus_we_done_i  : 1'b1;

   // Register jump with link
   assign jmp_o      = op_jmp;
   assign jmp_addr_o = exc.operand_1[`NCPU_AW-1:0];
   assign linkaddr   = `NCPU_DW'(exc.insn_pc + `NCPU_AW'd4);

   //////////////////////////////////////////////////////////////
   // Result select and write-back
   //////////////////////////////////////////////////////////////

   assign rd_o = ({`NCPU_DW{op_and}}   & lu_and)   |
                 ({`NCPU_DW{op_or}}    & lu_or)    |
                 ({`NCPU_DW{op_xor}}   & lu_xor)   |
                 ({`NCPU_DW{op_shift}} & lu_shift) |
                 ({`NCPU_DW{op_add}}   & au_sum)   |
                 ({`NCPU_DW{op_load}}  & d_i)      |
                 ({`NCPU_DW{op_jmp}}   & linkaddr);

   assign rd_addr_o = exc.wb_reg_addr;
   assign rd_we_o   = exc.pipe3_ready & exc.valid & exc.wb_en;

endmodule

// ==== verilog/ncpu32k_fetch.sv ====
/*
 * Fetch stage with PC, instruction bus request and a one-entry buffer
 * ibus_rd_o and iaddr_o are registered and held until insn_ready_i
 * Only one request is outstanding at a time
 * A word returning after a jump is discarded
 */
`timescale 1ns/10ps
`include "ncpu32k_macros.svh"

module ncpu32k_fetch (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic [`NCPU_IW-1:0] insn_i,
   input  logic                insn_ready_i,
   input  logic                pipe1_flow_i,  // Buffer taken by decode
   input  logic                jmp_i,
   input  logic [`NCPU_AW-1:0] jmp_addr_i,
   output logic [`NCPU_AW-1:0] iaddr_o,
   output logic                ibus_rd_o,
   output logic [`NCPU_IW-1:0] insn_o,
   output logic [`NCPU_AW-1:0] insn_pc_o,
   output logic                insn_valid_o
);
   ncpu32k_pkg::fetch_state_e state_q;
   logic                req_q;        // Request level on the bus
   logic [`NCPU_AW-1:0] iaddr_q;      // Address of the held request
   logic [`NCPU_AW-1:0] pc_q;         // Next address to request
   logic                buf_valid_q;
   logic [`NCPU_IW-1:0] buf_insn_q;
   logic [`NCPU_AW-1:0] buf_pc_q;
   logic                done;         // Word returns this cycle
   logic                keep;         // Word goes into the buffer
   logic                hold;         // Request still open next cycle
   logic                buf_valid_d;
   logic                issue;        // Start a new request next cycle
   logic [`NCPU_AW-1:0] pc_sel;

   assign done  = req_q & insn_ready_i;
   assign keep  = done & (state_q == ncpu32k_pkg::FETCH_REQ) & ~jmp_i;
   assign hold  = req_q & ~insn_ready_i;
   assign buf_valid_d = keep | (buf_valid_q & ~pipe1_flow_i & ~jmp_i);
   assign issue = ~hold & ~buf_valid_d;  // Buffer is free for the next word
   assign pc_sel = jmp_i ? jmp_addr_i : pc_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= ncpu32k_pkg::FETCH_REQ;
         req_q       <= 1'b0;
         iaddr_q     <= `NCPU_ERST_VECTOR;
         pc_q        <= `NCPU_ERST_VECTOR;
         buf_valid_q <= 1'b0;
      end else begin
         req_q       <= hold | issue;
         buf_valid_q <= buf_valid_d;
         if (issue) begin
            iaddr_q <= pc_sel;
            pc_q    <= pc_sel + `NCPU_AW'd4;
         end else if (jmp_i) begin
            pc_q    <= jmp_addr_i;  // Taken once the stale request returns
         end
         if (jmp_i && hold)
            state_q <= ncpu32k_pkg::FETCH_DROP;
         else if (done)
            state_q <= ncpu32k_pkg::FETCH_REQ;
      end
   end

   // Buffer payload
   always_ff @(posedge clk_i) begin
      if (keep) begin
         buf_insn_q <= insn_i;
         buf_pc_q   <= iaddr_q;
      end
   end

   assign iaddr_o      = iaddr_q;
   assign ibus_rd_o    = req_q;
   assign insn_o       = buf_insn_q;
   assign insn_pc_o    = buf_pc_q;
   assign insn_valid_o = buf_valid_q;

endmodule

// ==== verilog/ncpu32k_macros.svh ====
/*
 * Core-wide width and reset parameters
 * Data, address and instruction widths are all assumed equal to 32
 * Changing NCPU_REG_AW also resizes the register file
 */
`ifndef NCPU32K_MACROS_SVH
`define NCPU32K_MACROS_SVH

// Datapath widths
`define NCPU_DW 32
`define NCPU_AW 32
`define NCPU_IW 32

// Register file
`define NCPU_REG_AW 5
`define NCPU_REG_NUM (1 << `NCPU_REG_AW)

// PC after reset
`define NCPU_ERST_VECTOR 32'h0000_0000

`endif

// ==== verilog/ncpu32k_pkg.sv ====
/*
 * Shared types and instruction field layout
 * Opcode codes not listed in opcode_e are decoded as NOP
 * STW uses the rd field as the store data register
 */
package ncpu32k_pkg;

   // Six-bit major opcode
   typedef enum logic [5:0] {
      OPC_NOP    = 6'h00,
      OPC_AND    = 6'h01,
      OPC_OR     = 6'h02,
      OPC_XOR    = 6'h03,
      OPC_LSL    = 6'h04,
      OPC_LSR    = 6'h05,
      OPC_ASR    = 6'h06,
      OPC_ADD    = 6'h07,
      OPC_ADDI   = 6'h08,
      OPC_LDW    = 6'h09,
      OPC_STW    = 6'h0a,
      OPC_JMPREG = 6'h0b
   } opcode_e;

   typedef enum logic {
      FETCH_REQ  = 1'b0,  // Outstanding word is wanted
      FETCH_DROP = 1'b1   // Outstanding word belongs to a squashed path
   } fetch_state_e;

   // Instruction fields
   localparam int OPC_MSB = 31;
   localparam int OPC_LSB = 26;
   localparam int RD_MSB  = 25;
   localparam int RD_LSB  = 21;
   localparam int RS1_MSB = 20;
   localparam int RS1_LSB = 16;
   localparam int RS2_MSB = 15;
   localparam int RS2_LSB = 11;
   localparam int IMM_MSB = 15;  // Overlaps rs2
   localparam int IMM_LSB = 0;

endpackage

// ==== verilog/ncpu32k_regfile.sv ====
/*
 * General purpose register file, two read ports and one write port
 * Reads are combinational and see a write of the same cycle
 * r0 is hard-wired to zero
 */
`timescale 1ns/10ps
`include "ncpu32k_macros.svh"

module ncpu32k_regfile (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic [`NCPU_REG_AW-1:0] rs1_addr_i,
   input  logic [`NCPU_REG_AW-1:0] rs2_addr_i,
   input  logic [`NCPU_REG_AW-1:0] rd_addr_i,
   input  logic [`NCPU_DW-1:0]     rd_i,
   input  logic                    rd_we_i,
   output logic [`NCPU_DW-1:0]     rs1_o,
   output logic [`NCPU_DW-1:0]     rs2_o
);
   logic [`NCPU_DW-1:0] regs_q [1:`NCPU_REG_NUM-1];  // No storage for r0

   // Read with write-through so decode sees the write-back of this cycle
   always_comb begin
      if (rs1_addr_i == '0)
         rs1_o = '0;
      else if (rd_we_i && (rd_addr_i == rs1_addr_i))
         rs1_o = rd_i;
      else
         rs1_o = regs_q[rs1_addr_i];
      if (rs2_addr_i == '0)
         rs2_o = '0;
      else if (rd_we_i && (rd_addr_i == rs2_addr_i))
         rs2_o = rd_i;
      else
         rs2_o = regs_q[rs2_addr_i];
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 1; i < `NCPU_REG_NUM; i++) begin
            regs_q[i] <= '0;
         end
      end else if (rd_we_i && (rd_addr_i != '0)) begin  // Writes to r0 dropped
         regs_q[rd_addr_i] <= rd_i;
      end
   end

endmodule
